// File: ps2_game_input.f
rtl/game_input_pkg.sv
rtl/ps2_line_sampler.sv
rtl/ps2_frame_ctrl.sv
rtl/ps2_shift_reg.sv
rtl/keycode_assembler.sv
rtl/keycode_decoder.sv
rtl/ps2_game_input.sv
testbench/ps2_game_input_props.sv
testbench/ps2_game_input_tb.sv

// File: Makefile
TOP := ps2_game_input_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f ps2_game_input.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

// File: testbench/ps2_game_input_tb.sv
// testbench with ps2 frame driver, reference move model, jump window checks and random key events
`timescale 1ns/1ns
`default_nettype none

module ps2_game_input_tb;

    logic                        clk;
    logic                        rst;
    logic                        ps2_clk;
    logic                        ps2_data;
    game_input_pkg::game_moves_t moves;

    game_input_pkg::game_moves_t exp_moves;
    logic                        exp_pending; // model of the break prefix flag
    int                          errors;
    int                          cycle_cnt;
    int                          wait_cnt;
    logic                        seen_high;
    logic [7:0]                  code;
    logic                        brk;
    string                       test_name;
    event                        check_req;

    ps2_game_input DUT (
        .clk      (clk),
        .rst      (rst),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .moves    (moves)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // expected left and right after one received byte
    function automatic game_input_pkg::game_moves_t next_moves(
        input game_input_pkg::game_moves_t prev,
        input logic                        pending,
        input logic [7:0]                  b,
        input logic                        bad
    );
        game_input_pkg::game_moves_t m;
        m = prev;
        if (!bad && (b != game_input_pkg::sc_break) && (b != game_input_pkg::sc_ext)) begin
            if (b == game_input_pkg::sc_left) begin
                m.left = !pending;
            end else if (b == game_input_pkg::sc_right) begin
                m.right = !pending;
            end
        end
        return m;
    endfunction

    function automatic logic break_pending_after(input logic pending, input logic [7:0] b,
                                                 input logic bad);
        if (bad || (b == game_input_pkg::sc_ext)) begin
            return pending; // dropped bytes leave the flag alone
        end
        return (b == game_input_pkg::sc_break);
    endfunction

    // start, 8 data bits lsb first, odd parity, stop; 8 cycles per half bit
    task automatic send_byte(input logic [7:0] b, input logic bad);
        logic [10:0] frame;
        frame = {1'b1, (~^b) ^ bad, b, 1'b0};
        for (int i = 0; i < 11; i++) begin
            @(posedge clk);
            ps2_data <= frame[i];
            ps2_clk  <= 1'b1;
            repeat (8) @(posedge clk);
            ps2_clk  <= 1'b0; // device samples on this edge
            repeat (7) @(posedge clk);
        end
        @(posedge clk);
        ps2_clk  <= 1'b1;
        ps2_data <= 1'b1;
    endtask

    task automatic apply_byte(input string name, input logic [7:0] b, input logic bad);
        int gap;
        gap = $urandom % 31;
        repeat (gap) @(posedge clk);
        send_byte(b, bad);
        exp_moves   = next_moves(exp_moves, exp_pending, b, bad);
        exp_pending = break_pending_after(exp_pending, b, bad);
        repeat (20) @(posedge clk);
        @(negedge clk);
        test_name = name;
        -> check_req;
    endtask

    task automatic key_event(input string name, input logic [7:0] k, input logic is_break);
        if (is_break) begin
            apply_byte(name, game_input_pkg::sc_break, 1'b0);
        end
        apply_byte(name, k, 1'b0);
    endtask

    always @(check_req) begin
        if ((moves.left !== exp_moves.left) || (moves.right !== exp_moves.right)) begin
            errors++;
            $display("Error %s: expected left=%0b right=%0b, actual left=%0b right=%0b",
                     test_name, exp_moves.left, exp_moves.right, moves.left, moves.right);
        end
    end

    // about 60 frames of 230 cycles, plus reset and the jump windows
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= 60 * 230 + 600) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_cnt);
            $display("errors: %0d", errors);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'hf9a6_74c6));
        rst         = 1'b1;
        ps2_clk     = 1'b1;
        ps2_data    = 1'b1;
        exp_moves   = '0;
        exp_pending = 1'b0;
        errors      = 0;
        cycle_cnt   = 0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if (moves !== 3'b000) begin
            errors++;
            $display("Error reset: expected %03b, actual %03b", 3'b000, moves);
        end

        key_event("make_left", game_input_pkg::sc_left, 1'b0);
        key_event("make_right", game_input_pkg::sc_right, 1'b0);
        key_event("break_left", game_input_pkg::sc_left, 1'b1);
        key_event("break_right", game_input_pkg::sc_right, 1'b1);

        apply_byte("unlisted", 8'h15, 1'b0);
        apply_byte("ext_prefix", game_input_pkg::sc_ext, 1'b0);
        apply_byte("ext_code", 8'h75, 1'b0);

        key_event("parity_setup", game_input_pkg::sc_left, 1'b0);
        apply_byte("bad_parity", game_input_pkg::sc_right, 1'b1); // right is low here
        apply_byte("break_then_bad", game_input_pkg::sc_break, 1'b0);
        apply_byte("break_then_bad", game_input_pkg::sc_left, 1'b1);
        apply_byte("pending_consumed", 8'h15, 1'b0); // pending break goes here
        key_event("parity_cleanup", game_input_pkg::sc_left, 1'b1);

        apply_byte("jump_make", game_input_pkg::sc_jump, 1'b0);
        wait_cnt = 0;
        while (!moves.jump && (wait_cnt < 60)) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (!moves.jump) begin
            errors++;
            $display("jump never went high while W was held");
        end
        wait_cnt = 0;
        while (moves.jump && (wait_cnt <= int'(game_input_pkg::jump_hold) + 2)) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (moves.jump) begin
            errors++;
            $display("jump stayed high past %0d cycles", int'(game_input_pkg::jump_hold) + 2);
        end
        key_event("jump_break", game_input_pkg::sc_jump, 1'b1);
        seen_high = 1'b0;
        repeat (2 * (int'(game_input_pkg::jump_hold) + 2)) begin
            @(negedge clk);
            seen_high = seen_high | moves.jump;
        end
        if (seen_high) begin
            errors++;
            $display("jump went high again after W was released");
        end

        for (int n = 0; n < 20; n++) begin
            case ($urandom % 3)
                0:       code = game_input_pkg::sc_left;
                1:       code = game_input_pkg::sc_right;
                default: code = 8'h15;
            endcase
            brk = 1'($urandom % 2);
            key_event("random", code, brk);
        end

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/ps2_game_input_props.sv
// concurrent assertions on byte strobe, fsm start and jump strobe length, bound into the top
`timescale 1ns/1ns
`default_nettype none

module ps2_game_input_props (
    input logic                         clk,
    input logic                         rst,
    input logic                         fall,
    input game_input_pkg::ps2_byte_t    rx_byte,
    input game_input_pkg::frame_state_t state,
    input logic                         jump
);

    logic [7:0] hi_cnt; // consecutive cycles with jump high

    always_ff @(posedge clk) begin
        if (rst) begin
            hi_cnt <= 8'd0;
        end else if (jump) begin
            hi_cnt <= hi_cnt + 8'd1;
        end else begin
            hi_cnt <= 8'd0;
        end
    end

    valid_one_cycle: assert property (@(posedge clk) disable iff (rst)
        rx_byte.valid |=> !rx_byte.valid)
        else $error("rx_byte.valid held for more than one cycle");

    idle_exit_on_fall: assert property (@(posedge clk) disable iff (rst)
        (state == game_input_pkg::idle) && !fall |=> (state == game_input_pkg::idle))
        else $error("frame fsm left idle without a ps2 clock fall");

    jump_bounded: assert property (@(posedge clk) disable iff (rst)
        hi_cnt <= game_input_pkg::jump_hold + 8'd1)
        else $error("jump strobe high for too many cycles");

endmodule

bind ps2_game_input ps2_game_input_props u_props (
    .clk     (clk),
    .rst     (rst),
    .fall    (fall),
    .rx_byte (rx_byte),
    .state   (u_frame_ctrl.state),
    .jump    (moves.jump)
);

`default_nettype wire

// File: rtl/ps2_game_input.sv
// top level, sampler, frame control, shifter, keycode assembler and decoder
`timescale 1ns/1ns
`default_nettype none

module ps2_game_input (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        ps2_clk,
    input  logic                        ps2_data,
    output game_input_pkg::game_moves_t moves
);

    logic                      ps2_data_s;
    logic                      fall;
    logic                      shift_en;
    logic                      clr_parity;
    logic [7:0]                data_bits;
    logic                      parity_ok;
    game_input_pkg::ps2_byte_t rx_byte;
    logic [15:0]               keycode;

    ps2_line_sampler u_sampler (
        .clk        (clk),
        .rst        (rst),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_data),
        .ps2_data_s (ps2_data_s),
        .fall       (fall)
    );

    ps2_frame_ctrl u_frame_ctrl (
        .clk        (clk),
        .rst        (rst),
        .fall       (fall),
        .ps2_data_s (ps2_data_s),
        .shift_en   (shift_en),
        .clr_parity (clr_parity),
        .rx_byte    (rx_byte),
        .data_bits  (data_bits),
        .parity_ok  (parity_ok)
    );

    ps2_shift_reg u_shift_reg (
        .clk        (clk),
        .rst        (rst),
        .shift_en   (shift_en),
        .clr_parity (clr_parity),
        .ps2_data_s (ps2_data_s),
        .data_bits  (data_bits),
        .parity_ok  (parity_ok)
    );

    keycode_assembler u_assembler (
        .clk     (clk),
        .rst     (rst),
        .rx_byte (rx_byte),
        .keycode (keycode)
    );

    keycode_decoder u_decoder (
        .clk     (clk),
        .rst     (rst),
        .keycode (keycode),
        .moves   (moves)
    );

endmodule

`default_nettype wire

// File: rtl/keycode_decoder.sv
// keycode to held left and right levels and a repeating jump strobe
`timescale 1ns/1ns
`default_nettype none

module keycode_decoder (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [15:0]                 keycode,
    output game_input_pkg::game_moves_t moves
);

    game_input_pkg::game_moves_t moves_nxt;
    logic [7:0] ctr;
    logic [7:0] ctr_nxt;
    logic       is_break;
    logic [7:0] code;

    assign is_break = (keycode[15:8] == game_input_pkg::sc_break);
    assign code     = keycode[7:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            moves <= '0;
            ctr   <= 8'd0;
        end else begin
            moves <= moves_nxt;
            ctr   <= ctr_nxt;
        end
    end

    always_comb begin
        moves_nxt = moves;

        // directions are independent, both may be held
        if (code == game_input_pkg::sc_left) begin
            moves_nxt.left = ~is_break;
        end else if (code == game_input_pkg::sc_right) begin
            moves_nxt.right = ~is_break;
        end

        // jump pulses while the make persists
        if ((code == game_input_pkg::sc_jump) && !is_break) begin
            if (ctr > game_input_pkg::jump_hold) begin
                moves_nxt.jump = 1'b0; // one low cycle, then restart
                ctr_nxt        = 8'd0;
            end else begin
                moves_nxt.jump = 1'b1;
                ctr_nxt        = ctr + 8'd1;
            end
        end else begin
            moves_nxt.jump = 1'b0;
            ctr_nxt        = 8'd0;
        end
    end

endmodule

`default_nettype wire

// File: rtl/keycode_assembler.sv
// break prefix tracking and 16-bit keycode publishing from received bytes
`timescale 1ns/1ns
`default_nettype none

module keycode_assembler (
    input  logic                      clk,
    input  logic                      rst,
    input  game_input_pkg::ps2_byte_t rx_byte,
    output logic [15:0]               keycode
);

    logic pending_break;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending_break <= 1'b0;
            keycode       <= 16'h0000;
        end else if (rx_byte.valid && !rx_byte.err) begin
            if (rx_byte.data == game_input_pkg::sc_break) begin
                pending_break <= 1'b1; // wait for the released key
            end else if (rx_byte.data != game_input_pkg::sc_ext) begin
                // extended prefix falls through untouched
                keycode       <= {pending_break ? game_input_pkg::sc_break : 8'h00,
                                  rx_byte.data};
                pending_break <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/ps2_shift_reg.sv
// lsb first data shifter with running odd parity over data and parity bits
`timescale 1ns/1ns
`default_nettype none

module ps2_shift_reg (
    input  logic       clk,
    input  logic       rst,
    input  logic       shift_en,
    input  logic       clr_parity,
    input  logic       ps2_data_s,
    output logic [7:0] data_bits,
    output logic       parity_ok
);

    // nine stages, the parity bit lands on top and pushes d0 down to bit 0
    logic [8:0] sr;
    logic       ones_odd;

    always_ff @(posedge clk) begin
        if (shift_en) begin
            sr <= {ps2_data_s, sr[8:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst || clr_parity) begin
            ones_odd <= 1'b0;
        end else if (shift_en) begin
            ones_odd <= ones_odd ^ ps2_data_s; // toggle on every 1
        end
    end

    assign data_bits = sr[7:0];
    assign parity_ok = ones_odd;

endmodule

`default_nettype wire

// File: rtl/ps2_frame_ctrl.sv
// ps2 receive fsm for start, data, parity and stop with error flagging
`timescale 1ns/1ns
`default_nettype none

module ps2_frame_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    fall,
    input  logic                    ps2_data_s,
    output logic                    shift_en,
    output logic                    clr_parity,
    output game_input_pkg::ps2_byte_t rx_byte,
    input  logic [7:0]              data_bits,
    input  logic                    parity_ok
);

    game_input_pkg::frame_state_t state;
    logic [2:0] bit_cnt;
    logic       start_bad; // start bit was sampled high

    // data and parity bits both go through the shifter
    assign shift_en   = fall & ((state == game_input_pkg::data) ||
                                (state == game_input_pkg::parity));
    assign clr_parity = fall & (state == game_input_pkg::idle);

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= game_input_pkg::idle;
            bit_cnt       <= 3'd0;
            start_bad     <= 1'b0;
            rx_byte.valid <= 1'b0;
            rx_byte.err   <= 1'b0;
        end else begin
            rx_byte.valid <= 1'b0;
            if (fall) begin
                case (state)
                    game_input_pkg::idle: begin
                        start_bad <= ps2_data_s;
                        bit_cnt   <= 3'd0;
                        state     <= game_input_pkg::data;
                    end
                    game_input_pkg::data: begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= game_input_pkg::parity; // eighth bit taken
                        end
                    end
                    game_input_pkg::parity: begin
                        state <= game_input_pkg::stop;
                    end
                    game_input_pkg::stop: begin
                        // parity_ok already includes the parity bit here
                        rx_byte.valid <= 1'b1;
                        rx_byte.err   <= start_bad | ~parity_ok | ~ps2_data_s;
                        state         <= game_input_pkg::idle;
                    end
                    default: begin
                        state <= game_input_pkg::idle;
                    end
                endcase
            end
        end
    end

    // payload follows the stop bit, no reset needed
    always_ff @(posedge clk) begin
        if (fall && (state == game_input_pkg::stop)) begin
            rx_byte.data <= data_bits;
        end
    end

endmodule

`default_nettype wire

// File: rtl/ps2_line_sampler.sv
// ps2 clock and data synchronizers with a falling edge strobe on the synced clock
`timescale 1ns/1ns
`default_nettype none

module ps2_line_sampler (
    input  logic clk,
    input  logic rst,
    input  logic ps2_clk,
    input  logic ps2_data,
    output logic ps2_data_s,
    output logic fall
);

    logic clk_meta;
    logic clk_s;
    logic clk_prev;
    logic data_meta;

    // bus idles high, so all stages reset to 1
    always_ff @(posedge clk) begin
        if (rst) begin
            clk_meta   <= 1'b1;
            clk_s      <= 1'b1;
            clk_prev   <= 1'b1;
            data_meta  <= 1'b1;
            ps2_data_s <= 1'b1;
            fall       <= 1'b0;
        end else begin
            clk_meta   <= ps2_clk;
            clk_s      <= clk_meta;
            clk_prev   <= clk_s;
            data_meta  <= ps2_data;
            ps2_data_s <= data_meta;
            fall       <= clk_prev & ~clk_s; // registered edge, third cycle after the pin
        end
    end

endmodule

`default_nettype wire

// File: rtl/game_input_pkg.sv
// scan code and jump hold constants, frame state enum, ps2 byte and game move structs
`default_nettype none

package game_input_pkg;

    // set 2 make codes for the game keys
    localparam logic [7:0] sc_left  = 8'h1C; // A
    localparam logic [7:0] sc_right = 8'h23; // D
    localparam logic [7:0] sc_jump  = 8'h1D; // W

    // prefixes
    localparam logic [7:0] sc_break = 8'hF0; // key release
    localparam logic [7:0] sc_ext   = 8'hE0; // extended key, dropped

    // counter value after which the jump strobe drops for a cycle
    localparam logic [7:0] jump_hold = 8'd50;

    // receive fsm, start bit is taken in idle
    typedef enum logic [1:0] {
        idle,
        data,
        parity,
        stop
    } frame_state_t;

    // one received ps2 byte
    typedef struct packed {
        logic       valid; // one cycle strobe
        logic       err;   // start, parity or stop failure
        logic [7:0] data;
    } ps2_byte_t;

    typedef struct packed {
        logic right;
        logic left;
        logic jump;
    } game_moves_t;

endpackage

`default_nettype wire
